// File: sim/mant_alu_testdata.txt
# name op a b cin result carry ge lz_count
# all numbers hex, op 0 add 1 sub 2 cmp 3 shr 4 shl 5 norm
add_grp0_carry 0 0000ff 000001 0 000100 0 1 10
add_grp1_carry 0 00ff00 000100 0 010000 0 1 08
add_all_ones 0 ffffff 000001 0 000000 1 1 00
add_cin 0 00ffff 000000 1 010000 0 1 08
add_mixed 0 123456 654321 1 777778 0 0 03
add_overflow 0 800000 800000 0 000000 1 1 00
sub_gt 1 000010 000003 1 00000d 1 1 13
sub_eq 1 abcdef abcdef 0 000000 1 1 00
sub_lt 1 000003 000010 0 fffff3 0 0 16
sub_grp_borrow 1 010000 000001 0 00ffff 1 1 07
cmp_b_big 2 000001 ffffff 0 ffffff 0 0 17
cmp_low_grp 2 123400 123401 0 123401 0 0 03
cmp_low_grp_ge 2 123456 123455 1 123456 0 1 03
cmp_equal 2 5a5a5a 5a5a5a 0 5a5a5a 0 1 01
shr_0 3 c00001 000000 0 c00001 0 1 00
shr_1 3 c00001 000001 0 600000 0 1 00
shr_23 3 c00001 000017 0 000001 0 1 00
shr_24 3 c00001 000018 0 000000 0 1 00
shr_200 3 c00001 0000c8 0 000000 0 1 00
shl_0 4 c00001 000000 0 c00001 0 1 00
shl_1 4 c00001 000001 0 800002 0 1 00
shl_23 4 c00001 000017 0 800000 0 1 00
shl_24 4 c00001 000018 0 000000 0 1 00
shl_200 4 c00001 0000c8 1 000000 0 1 00
shl_low_byte 4 c00001 ff0002 0 000004 0 0 00
norm_grp2 5 400000 000000 0 800000 0 1 01
norm_grp1 5 00a5c3 000000 0 a5c300 0 1 08
norm_grp0 5 00002f 000000 0 bc0000 0 1 12
norm_one 5 000001 000000 0 800000 0 1 17
norm_zero 5 000000 000000 0 000000 0 1 18

// File: src.f
hw/fp_mant_pkg.sv
hw/cla_adder.sv
hw/mag_compare.sv
hw/mant_shifter.sv
hw/lead_zero_count.sv
hw/mant_alu.sv
sim/tb_clock_gen.sv
sim/mant_alu_props.sv
sim/mant_alu_tb.sv

// File: Makefile
# Verilator flow for the mantissa datapath, run from the project root

TOP := mant_alu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/mant_alu_tb.sv
// runs from the project root with MANT_W at 24, since the vector file holds 24-bit values
`timescale 1ns/1ps

module mant_alu_tb
	import fp_mant_pkg::*;
();

	localparam int MANT_W = MANT_W_DEF;
	localparam int CNT_W = $clog2(MANT_W + 1);
	localparam string DATA_FILE = "sim/mant_alu_testdata.txt";

	logic              clk;
	logic              rst;
	logic              op_valid;
	mant_op_t          op;
	logic [MANT_W-1:0] a;
	logic [MANT_W-1:0] b;
	logic              cin;
	logic              result_valid;
	logic [MANT_W-1:0] result;
	logic              carry;
	logic              ge;
	logic [CNT_W-1:0]  lz_count;

	// one entry per vector line
	string             vec_name[$];
	logic [2:0]        vec_op[$];
	logic [MANT_W-1:0] vec_a[$];
	logic [MANT_W-1:0] vec_b[$];
	logic              vec_cin[$];
	logic [MANT_W-1:0] vec_res[$];
	logic              vec_carry[$];
	logic              vec_ge[$];
	logic [CNT_W-1:0]  vec_lz[$];

	int mismatches;
	int other_errors;
	int checked;
	int cycle_limit;
	int cycle_count = 0;

	tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.clk(clk));

	mant_alu #(.MANT_W(MANT_W)) i_mant_alu (
		.clk(clk), .rst(rst), .op_valid(op_valid), .op(op), .a(a), .b(b), .cin(cin),
		.result_valid(result_valid), .result(result), .carry(carry), .ge(ge),
		.lz_count(lz_count)
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic load_vectors();
		int fd;
		int r;
		string line;
		string t_name;
		logic [31:0] t_op, t_a, t_b, t_cin, t_res, t_carry, t_ge, t_lz;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("could not open the test data file %s", DATA_FILE);
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			r = $fgets(line, fd);
			// lines starting with # describe the columns
			if (r > 0 && line[0] != "#") begin
				r = $sscanf(line, "%s %h %h %h %h %h %h %h %h", t_name, t_op, t_a, t_b,
				            t_cin, t_res, t_carry, t_ge, t_lz);
				if (r == 9) begin
					vec_name.push_back(t_name);
					vec_op.push_back(t_op[2:0]);
					vec_a.push_back(t_a[MANT_W-1:0]);
					vec_b.push_back(t_b[MANT_W-1:0]);
					vec_cin.push_back(t_cin[0]);
					vec_res.push_back(t_res[MANT_W-1:0]);
					vec_carry.push_back(t_carry[0]);
					vec_ge.push_back(t_ge[0]);
					vec_lz.push_back(t_lz[CNT_W-1:0]);
				end else if (r > 0) begin
					$display("could not parse test data line: %s", line);
					other_errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_vector(input int i);
		op_valid = 1'b1;
		op = mant_op_t'(vec_op[i]);
		a = vec_a[i];
		b = vec_b[i];
		cin = vec_cin[i];
	endtask

	// drop the strobe and change the operands, so only a held result still matches
	task automatic drive_idle();
		op_valid = 1'b0;
		a = ~a;
		b = ~b;
		cin = ~cin;
	endtask

	task automatic check_vector(input int i);
		checked++;
		if (result_valid !== 1'b1) begin
			$display("result_valid stayed low one cycle after vector %s", vec_name[i]);
			other_errors++;
		end else begin
			if (result !== vec_res[i]) begin
				$display("mismatch %s result expected %h actual %h", vec_name[i],
				         vec_res[i], result);
				mismatches++;
			end
			if (carry !== vec_carry[i]) begin
				$display("mismatch %s carry expected %b actual %b", vec_name[i],
				         vec_carry[i], carry);
				mismatches++;
			end
			if (ge !== vec_ge[i]) begin
				$display("mismatch %s ge expected %b actual %b", vec_name[i], vec_ge[i], ge);
				mismatches++;
			end
			if (lz_count !== vec_lz[i]) begin
				$display("mismatch %s lz_count expected %h actual %h", vec_name[i],
				         vec_lz[i], lz_count);
				mismatches++;
			end
		end
	endtask

	// no strobe last cycle, so no pulse and the old result and flags stay
	task automatic check_idle(input string where, input logic [MANT_W-1:0] held_res,
	                          input logic held_carry, input logic held_ge,
	                          input logic [CNT_W-1:0] held_lz);
		if (result_valid !== 1'b0) begin
			$display("result_valid was high %s although no operation was strobed", where);
			other_errors++;
		end
		if (result !== held_res) begin
			$display("mismatch %s held result expected %h actual %h", where, held_res,
			         result);
			mismatches++;
		end
		if (carry !== held_carry) begin
			$display("mismatch %s held carry expected %b actual %b", where, held_carry,
			         carry);
			mismatches++;
		end
		if (ge !== held_ge) begin
			$display("mismatch %s held ge expected %b actual %b", where, held_ge, ge);
			mismatches++;
		end
		if (lz_count !== held_lz) begin
			$display("mismatch %s held lz_count expected %h actual %h", where, held_lz,
			         lz_count);
			mismatches++;
		end
	endtask

	//////////////////////////////
	// run
	//////////////////////////////

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		int n;
		rst = 1'b1;
		op_valid = 1'b0;
		op = OP_ADD;
		a = '0;
		b = '0;
		cin = 1'b0;
		mismatches = 0;
		other_errors = 0;
		checked = 0;
		cycle_limit = 20;
		load_vectors();
		n = vec_name.size();
		cycle_limit = 20 + 3 * n;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		drive_idle();
		@(negedge clk);
		check_idle("after reset", '0, 1'b0, 1'b0, '0);
		// back to back strobes, with one idle cycle halfway
		for (int i = 0; i < n; i++) begin
			if (i > 0 && i == n / 2) begin
				drive_idle();
				@(negedge clk);
				check_idle("in the gap", vec_res[i-1], vec_carry[i-1], vec_ge[i-1],
				           vec_lz[i-1]);
			end
			drive_vector(i);
			@(negedge clk);
			check_vector(i);
		end
		drive_idle();
		@(negedge clk);
		if (n > 0) begin
			check_idle("after the last vector", vec_res[n-1], vec_carry[n-1], vec_ge[n-1],
			           vec_lz[n-1]);
		end else begin
			$display("no test vectors were read");
			other_errors++;
		end
		$display("errors: %0d mismatches, %0d other failures, %0d vectors checked",
		         mismatches, other_errors, checked);
		if (mismatches == 0 && other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim/mant_alu_props.sv
// bound to mant_alu and covers only strobe timing, reset values and the carry flag
`timescale 1ns/1ps

module mant_alu_props
	import fp_mant_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     op_valid,
	input mant_op_t op,
	input logic     result_valid,
	input logic     carry
);

	// exactly one pulse per strobe, one cycle later
	a_pulse_follows_strobe: assert property (@(posedge clk) disable iff (rst)
		op_valid |=> result_valid)
		else $error("result_valid did not follow op_valid by one cycle");

	a_no_pulse_without_strobe: assert property (@(posedge clk) disable iff (rst)
		!op_valid |=> !result_valid)
		else $error("result_valid rose without an op_valid one cycle before");

	a_reset_clears: assert property (@(posedge clk)
		rst |=> (!result_valid && !carry))
		else $error("result_valid or carry set in the cycle after reset");

	// only add and subtract may raise carry
	a_carry_only_arith: assert property (@(posedge clk) disable iff (rst)
		(op_valid && op != OP_ADD && op != OP_SUB) |=> !carry)
		else $error("carry set after an operation other than add or subtract");

endmodule

bind mant_alu mant_alu_props i_mant_alu_props (
	.clk(clk), .rst(rst), .op_valid(op_valid), .op(op),
	.result_valid(result_valid), .carry(carry)
);

// File: sim/tb_clock_gen.sv
// free-running from time zero, starts low, and PERIOD_NS should be even
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: hw/mant_alu.sv
// one operation per op_valid with the result one cycle later and no back-pressure
`timescale 1ns/1ps

module mant_alu
	import fp_mant_pkg::*;
#(
	parameter int MANT_W = MANT_W_DEF
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          op_valid,
	input  mant_op_t                      op,
	input  logic [MANT_W-1:0]             a,
	input  logic [MANT_W-1:0]             b,
	input  logic                          cin,
	output logic                          result_valid,
	output logic [MANT_W-1:0]             result,
	output logic                          carry,
	output logic                          ge,
	output logic [$clog2(MANT_W + 1)-1:0] lz_count
);

	localparam int CNT_W = $clog2(MANT_W + 1);

	logic [MANT_W-1:0]  add_y;
	logic [MANT_W-1:0]  add_sum;
	logic               add_cin;
	logic               add_cout;
	logic               a_ge_b;
	logic [SHAMT_W-1:0] sh_amt;
	logic               sh_left;
	logic [MANT_W-1:0]  sh_out;
	logic [CNT_W-1:0]   lz;
	logic [MANT_W-1:0]  res_d;
	logic               carry_d;
	logic               is_sub;
	logic               is_norm;

	//////////////////////////////
	// operation decode
	//////////////////////////////

	assign is_sub  = op == OP_SUB;
	assign is_norm = op == OP_NORM;

	// subtract is a + ~b + 1
	assign add_y   = is_sub ? ~b : b;
	assign add_cin = is_sub ? 1'b1 : cin;

	assign sh_amt  = is_norm ? SHAMT_W'(lz) : b[SHAMT_W-1:0];
	assign sh_left = is_norm || (op == OP_SHL);

	cla_adder #(.MANT_W(MANT_W)) i_cla_adder (
		.x(a), .y(add_y), .cin(add_cin), .sum(add_sum), .cout(add_cout)
	);

	mag_compare #(.MANT_W(MANT_W)) i_mag_compare (
		.x(a), .y(b), .x_ge_y(a_ge_b)
	);

	mant_shifter #(.MANT_W(MANT_W)) i_mant_shifter (
		.x(a), .amount(sh_amt), .left(sh_left), .shifted(sh_out)
	);

	lead_zero_count #(.MANT_W(MANT_W)) i_lead_zero_count (
		.x(a), .count(lz)
	);

	// result select, carry only meaningful for add and sub
	always_comb begin
		res_d = '0;
		carry_d = 1'b0;
		case (op)
			OP_ADD, OP_SUB: begin
				res_d = add_sum;
				carry_d = add_cout;
			end
			OP_CMP: res_d = a_ge_b ? a : b;
			OP_SHR, OP_SHL, OP_NORM: res_d = sh_out;
			default: res_d = '0;
		endcase
	end

	//////////////////////////////
	// output registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			result <= '0;
			carry <= 1'b0;
			ge <= 1'b0;
			lz_count <= '0;
		end else begin
			result_valid <= op_valid;
			// hold the last result until the next strobe
			if (op_valid) begin
				result <= res_d;
				carry <= carry_d;
				ge <= a_ge_b;
				lz_count <= lz;
			end
		end
	end

endmodule

// File: hw/lead_zero_count.sv
// MANT_W must be a multiple of GROUP_W and an all-zero input counts as MANT_W
`timescale 1ns/1ps

module lead_zero_count
	import fp_mant_pkg::*;
#(
	parameter int MANT_W = MANT_W_DEF
) (
	input  logic [MANT_W-1:0]              x,
	output logic [$clog2(MANT_W + 1)-1:0] count
);

	localparam int CNT_W = $clog2(MANT_W + 1);
	localparam int N_GRP = MANT_W / GROUP_W;

	logic [N_GRP-1:0] grp_nz;
	logic [N_GRP-1:0][CNT_W-1:0] grp_lz;

	// first level, one priority encoder per group
	always_comb begin
		for (int gi = 0; gi < N_GRP; gi++) begin
			grp_nz[gi] = |x[gi*GROUP_W +: GROUP_W];
			grp_lz[gi] = '0;
			for (int i = 0; i < GROUP_W; i++) begin
				if (x[gi*GROUP_W + i]) begin
					grp_lz[gi] = CNT_W'(GROUP_W - 1 - i);
				end
			end
		end
	end

	// second level picks the highest group holding a one
	always_comb begin : pick
		logic found;
		count = CNT_W'(MANT_W);
		found = 1'b0;
		for (int gi = N_GRP - 1; gi >= 0; gi--) begin
			if (!found && grp_nz[gi]) begin
				count = CNT_W'((N_GRP - 1 - gi) * GROUP_W) + grp_lz[gi];
				found = 1'b1;
			end
		end
	end

endmodule

// File: hw/mant_shifter.sv
// logical shifts only and any amount above MANT_W minus one gives zero
`timescale 1ns/1ps

module mant_shifter
	import fp_mant_pkg::*;
#(
	parameter int MANT_W = MANT_W_DEF
) (
	input  logic [MANT_W-1:0]  x,
	input  logic [SHAMT_W-1:0] amount,
	input  logic               left,
	output logic [MANT_W-1:0]  shifted
);

	localparam int STG = $clog2(MANT_W);

	logic [MANT_W-1:0] src;
	logic [MANT_W-1:0] barrel_out;
	logic [MANT_W-1:0] unrev;
	logic              too_far;

	// left shift reuses the right barrel on bit-reversed data
	always_comb begin
		for (int i = 0; i < MANT_W; i++) begin
			src[i] = left ? x[MANT_W-1-i] : x[i];
		end
	end

	always_comb begin : barrel
		logic [MANT_W-1:0] v;
		v = src;
		for (int s = 0; s < STG; s++) begin
			if (amount[s]) begin
				v = v >> (1 << s);
			end
		end
		barrel_out = v;
	end

	always_comb begin
		for (int i = 0; i < MANT_W; i++) begin
			unrev[i] = left ? barrel_out[MANT_W-1-i] : barrel_out[i];
		end
	end

	// saturate oversized amounts
	assign too_far = amount > SHAMT_W'(MANT_W - 1);
	assign shifted = too_far ? '0 : unrev;

endmodule

// File: hw/mag_compare.sv
// unsigned compare only and MANT_W must be a multiple of GROUP_W
`timescale 1ns/1ps

module mag_compare
	import fp_mant_pkg::*;
#(
	parameter int MANT_W = MANT_W_DEF
) (
	input  logic [MANT_W-1:0] x,
	input  logic [MANT_W-1:0] y,
	output logic              x_ge_y
);

	localparam int N_GRP = MANT_W / GROUP_W;

	logic [N_GRP-1:0] grp_gt;
	logic [N_GRP-1:0] grp_eq;

	// per group greater-than and equality
	always_comb begin
		for (int gi = 0; gi < N_GRP; gi++) begin
			grp_gt[gi] = x[gi*GROUP_W +: GROUP_W] > y[gi*GROUP_W +: GROUP_W];
			grp_eq[gi] = x[gi*GROUP_W +: GROUP_W] == y[gi*GROUP_W +: GROUP_W];
		end
	end

	// top unequal group decides, all equal means ge
	always_comb begin : decide
		logic decided;
		x_ge_y = 1'b1;
		decided = 1'b0;
		for (int gi = N_GRP - 1; gi >= 0; gi--) begin
			if (!decided && !grp_eq[gi]) begin
				x_ge_y = grp_gt[gi];
				decided = 1'b1;
			end
		end
	end

endmodule

// File: hw/cla_adder.sv
// MANT_W must be a multiple of GROUP_W and the group carries ripple from the low group upward
`timescale 1ns/1ps

module cla_adder
	import fp_mant_pkg::*;
#(
	parameter int MANT_W = MANT_W_DEF
) (
	input  logic [MANT_W-1:0] x,
	input  logic [MANT_W-1:0] y,
	input  logic              cin,
	output logic [MANT_W-1:0] sum,
	output logic              cout
);

	localparam int N_GRP = MANT_W / GROUP_W;

	logic [MANT_W-1:0] g;
	logic [MANT_W-1:0] p;
	logic [MANT_W-1:0] c_bit;

	// carry into bit k of a group as a flat sum of products
	function automatic logic cla_carry(input logic [GROUP_W-1:0] gg,
	                                   input logic [GROUP_W-1:0] pp,
	                                   input logic c0,
	                                   input int k);
		logic term;
		logic carry;
		carry = 1'b0;
		for (int j = 0; j < k; j++) begin
			term = gg[j];
			for (int m = j + 1; m < k; m++) begin
				term = term & pp[m];
			end
			carry = carry | term;
		end
		// cin propagated through every lower bit
		term = c0;
		for (int m = 0; m < k; m++) begin
			term = term & pp[m];
		end
		return carry | term;
	endfunction

	assign g = x & y;
	assign p = x | y;

	always_comb begin : carry_chain
		logic c_grp;
		c_grp = cin;
		for (int gi = 0; gi < N_GRP; gi++) begin
			for (int k = 0; k < GROUP_W; k++) begin
				c_bit[gi*GROUP_W + k] = cla_carry(g[gi*GROUP_W +: GROUP_W],
				                                  p[gi*GROUP_W +: GROUP_W], c_grp, k);
			end
			// group carry out feeds the next group
			c_grp = cla_carry(g[gi*GROUP_W +: GROUP_W], p[gi*GROUP_W +: GROUP_W], c_grp, GROUP_W);
		end
		cout = c_grp;
	end

	assign sum = x ^ y ^ c_bit;

endmodule

// File: hw/fp_mant_pkg.sv
// shared widths and opcodes for the mantissa datapath, and MANT_W must be a multiple of GROUP_W
package fp_mant_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// lookahead and compare group size
	localparam int GROUP_W = 8;

	// single precision significand with the hidden bit
	localparam int MANT_W_DEF = 24;

	// shift amount port width
	localparam int SHAMT_W = 8;

	//////////////////////////////
	// operations
	//////////////////////////////

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_CMP  = 3'd2,
		OP_SHR  = 3'd3,
		OP_SHL  = 3'd4,
		OP_NORM = 3'd5
	} mant_op_t;

endpackage
